// ==== src/rob_pkg.sv ====
`default_nettype none

package rob_pkg;

    localparam int xlen        = 32; // data and address width
    localparam int rob_size    = 8;
    localparam int rob_tag_len = 3;  // enough bits to index rob_size entries

    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_slt = 3'd5  // signed compare
    } alu_op_t;

    // one broadcast on the common data bus
    typedef struct packed {
        logic                   valid;
        logic [rob_tag_len-1:0] rob_tag;
        logic [xlen-1:0]        value;
    } cdb_data_t;

    typedef struct packed {
        logic                   valid;
        logic                   wr_mem;        // entry is a store
        logic [4:0]             dest_reg;
        logic [xlen-1:0]        dest_addr;     // store address, from the AGU
        logic [xlen-1:0]        value;         // result, or store data
        logic [rob_tag_len-1:0] store_dep;     // producer of the store data
        logic                   value_ready;
        logic                   address_ready; // set at allocation for non-stores
    } rob_entry_t;

endpackage

`default_nettype wire

// ==== src/fu_result_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// result path from one execution unit to the CDB arbiter
interface fu_result_if;
    import rob_pkg::*;

    logic                   valid;
    logic [rob_tag_len-1:0] rob_tag;
    logic [xlen-1:0]        value;
    logic                   ready;   // arbiter takes the result this cycle

    modport producer (output valid, output rob_tag, output value, input ready);

    modport consumer (input valid, input rob_tag, input value, output ready);

endinterface

`default_nettype wire

// ==== src/alu_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu_unit (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            issue_valid,
    input  logic [rob_pkg::rob_tag_len-1:0] issue_tag,
    input  rob_pkg::alu_op_t                issue_op,
    input  logic [rob_pkg::xlen-1:0]        operand_a,
    input  logic [rob_pkg::xlen-1:0]        operand_b,
    output logic                            issue_ready,
    fu_result_if.producer                   result
);
    import rob_pkg::*;

    logic                   s1_valid;
    logic [rob_tag_len-1:0] s1_tag;
    alu_op_t                s1_op;
    logic [xlen-1:0]        s1_a;
    logic [xlen-1:0]        s1_b;
    logic [xlen-1:0]        s1_result;
    logic                   stall;

    // stage 2 holds a result the arbiter has not taken, so everything waits
    assign stall       = result.valid && !result.ready;
    assign issue_ready = !stall;

    always_comb begin
        case (s1_op)
            alu_add: s1_result = s1_a + s1_b;
            alu_sub: s1_result = s1_a - s1_b;
            alu_and: s1_result = s1_a & s1_b;
            alu_or:  s1_result = s1_a | s1_b;
            alu_xor: s1_result = s1_a ^ s1_b;
            alu_slt: s1_result = xlen'($signed(s1_a) < $signed(s1_b));
            default: s1_result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            s1_valid     <= 1'b0;
            result.valid <= 1'b0;
        end else if (!stall) begin
            s1_valid     <= issue_valid;
            result.valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            s1_tag         <= issue_tag;
            s1_op          <= issue_op;
            s1_a           <= operand_a;
            s1_b           <= operand_b;
            result.rob_tag <= s1_tag;    // stage 2
            result.value   <= s1_result;
        end
    end

endmodule

`default_nettype wire

// ==== src/agu_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module agu_unit (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            issue_valid,
    input  logic [rob_pkg::rob_tag_len-1:0] issue_tag,
    input  logic [rob_pkg::xlen-1:0]        base,
    input  logic [rob_pkg::xlen-1:0]        offset,
    output logic                            issue_ready,
    fu_result_if.producer                   result
);

    logic stall;

    assign stall       = result.valid && !result.ready; // address not yet on the CDB
    assign issue_ready = !stall;

    always_ff @(posedge clock) begin
        if (reset) begin
            result.valid <= 1'b0;
        end else if (!stall) begin
            result.valid <= issue_valid;
        end
    end

    // address register holds while stalled
    always_ff @(posedge clock) begin
        if (issue_valid && !stall) begin
            result.rob_tag <= issue_tag;
            result.value   <= base + offset;
        end
    end

endmodule

`default_nettype wire

// ==== src/cdb_arbiter.sv ====
`timescale 1ns/10ps
`default_nettype none

// fixed priority, the ALU wins over the AGU
module cdb_arbiter (
    input  logic                clock,
    input  logic                reset,
    fu_result_if.consumer       alu_result,
    fu_result_if.consumer       agu_result,
    output rob_pkg::cdb_data_t  cdb
);

    logic alu_grant;
    logic agu_grant;

    assign alu_grant = alu_result.valid;
    assign agu_grant = agu_result.valid && !alu_result.valid;

    // a source that loses keeps its result and sees ready low
    assign alu_result.ready = alu_grant;
    assign agu_result.ready = agu_grant;

    always_ff @(posedge clock) begin
        if (reset) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= alu_grant || agu_grant; // no grant means an idle bus
            if (alu_grant) begin
                cdb.rob_tag <= alu_result.rob_tag;
                cdb.value   <= alu_result.value;
            end else if (agu_grant) begin
                cdb.rob_tag <= agu_result.rob_tag;
                cdb.value   <= agu_result.value;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/rob.sv ====
`timescale 1ns/10ps
`default_nettype none

module rob (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            alloc_enable,
    input  logic                            alloc_wr_mem,         // new entry is a store
    input  logic [rob_pkg::xlen-1:0]        alloc_value_in,       // store data if known now
    input  logic                            alloc_value_in_valid,
    input  logic [rob_pkg::rob_tag_len-1:0] alloc_store_dep,      // otherwise its producer
    input  logic [4:0]                      dest_reg,
    input  rob_pkg::cdb_data_t              cdb,
    input  logic [rob_pkg::rob_tag_len-1:0] read_rob_tag,
    input  logic [rob_pkg::xlen-1:0]        load_address,
    input  logic [rob_pkg::rob_tag_len-1:0] load_rob_tag,
    output logic                            full,
    output logic [rob_pkg::rob_tag_len-1:0] alloc_slot,
    output logic [rob_pkg::xlen-1:0]        read_value,
    output logic                            pending_stores,
    output rob_pkg::rob_entry_t             head_entry,
    output logic                            head_ready
);
    import rob_pkg::*;

    rob_entry_t             entries [rob_size];
    logic [rob_tag_len-1:0] head;
    logic [rob_tag_len-1:0] tail;
    logic [rob_tag_len-1:0] head_next;
    logic [rob_tag_len-1:0] tail_next;
    logic                   allocate_tail;
    logic [xlen-1:0]        alloc_value;
    logic                   alloc_value_ready;
    logic                   cdb_is_store;
    logic [rob_tag_len-1:0] pend_walk;
    logic                   pend_active;

    function automatic logic [rob_tag_len-1:0] tag_inc(input logic [rob_tag_len-1:0] t);
        return (t == rob_tag_len'(rob_size - 1)) ? '0 : t + 1'b1;
    endfunction

    function automatic logic [rob_tag_len-1:0] tag_dec(input logic [rob_tag_len-1:0] t);
        return (t == '0) ? rob_tag_len'(rob_size - 1) : t - 1'b1;
    endfunction

    // a broadcast for a store carries its address, anything else a value
    assign cdb_is_store = entries[cdb.rob_tag].wr_mem;

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < rob_size; i++) begin
                entries[i].valid         <= 1'b0;
                entries[i].wr_mem        <= 1'b0;
                entries[i].value_ready   <= 1'b0;
                entries[i].address_ready <= 1'b0;
            end
        end else begin
            if (cdb.valid) begin
                if (cdb_is_store) begin
                    entries[cdb.rob_tag].dest_addr     <= cdb.value;
                    entries[cdb.rob_tag].address_ready <= 1'b1;
                end else begin
                    for (int i = 0; i < rob_size; i++) begin
                        // the tagged entry plus any store still waiting on it
                        if (i == int'(cdb.rob_tag) ||
                            (entries[i].wr_mem && !entries[i].value_ready &&
                             entries[i].store_dep == cdb.rob_tag)) begin
                            entries[i].value       <= cdb.value;
                            entries[i].value_ready <= 1'b1;
                        end
                    end
                end
            end

            if (head_ready) begin  // commit
                entries[head].valid         <= 1'b0;
                entries[head].wr_mem        <= 1'b0;
                entries[head].value_ready   <= 1'b0;
                entries[head].address_ready <= 1'b0;
            end

            // after the commit clear, so the freed head slot can be reused at once
            if (allocate_tail) begin
                entries[tail] <= '{valid:         1'b1,
                                   wr_mem:        alloc_wr_mem,
                                   dest_reg:      dest_reg,
                                   dest_addr:     '0,
                                   value:         alloc_value,
                                   store_dep:     alloc_store_dep,
                                   value_ready:   alloc_value_ready,
                                   address_ready: !alloc_wr_mem};
            end

            head <= head_next;
            tail <= tail_next;
        end
    end

    // store data can arrive on the CDB in the allocating cycle
    always_comb begin
        alloc_value       = alloc_value_in;
        alloc_value_ready = alloc_wr_mem && alloc_value_in_valid;
        if (alloc_wr_mem && !alloc_value_in_valid && cdb.valid && !cdb_is_store &&
            alloc_store_dep == cdb.rob_tag) begin
            alloc_value       = cdb.value;
            alloc_value_ready = 1'b1;
        end
    end

    // walk back from the load towards the head
    always_comb begin
        pending_stores = 1'b0;
        pend_walk      = load_rob_tag;
        pend_active    = entries[load_rob_tag].valid && load_rob_tag != head;
        for (int i = 0; i < rob_size - 1; i++) begin
            if (pend_active) begin
                pend_walk = tag_dec(pend_walk);
                if (entries[pend_walk].valid && entries[pend_walk].wr_mem &&
                    entries[pend_walk].address_ready &&
                    entries[pend_walk].dest_addr == load_address) begin
                    pending_stores = 1'b1;
                end
                if (pend_walk == head) begin
                    pend_active = 1'b0; // head was the oldest, stop here
                end
            end
        end
    end

    assign head_ready    = entries[head].valid && entries[head].value_ready &&
                           entries[head].address_ready;
    assign full          = entries[head].valid && tail == head && !head_ready;
    assign allocate_tail = alloc_enable && !full;
    assign head_next     = head_ready ? tag_inc(head) : head;
    assign tail_next     = allocate_tail ? tag_inc(tail) : tail;
    assign alloc_slot    = tail;
    assign read_value    = entries[read_rob_tag].value;
    assign head_entry    = entries[head];

endmodule

`default_nettype wire

// ==== src/rob_core_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module rob_core_top (
    input  logic                            clock,
    input  logic                            reset,
    // allocation, in program order
    input  logic                            alloc_enable,
    input  logic                            alloc_is_store,
    input  logic [4:0]                      alloc_dest_reg,
    input  logic [rob_pkg::xlen-1:0]        alloc_store_value,
    input  logic                            alloc_store_value_valid,
    input  logic [rob_pkg::rob_tag_len-1:0] alloc_store_dep,
    output logic [rob_pkg::rob_tag_len-1:0] alloc_tag,
    output logic                            full,
    // ALU issue
    input  logic                            alu_issue_valid,
    input  logic [rob_pkg::rob_tag_len-1:0] alu_issue_tag,
    input  rob_pkg::alu_op_t                alu_issue_op,
    input  logic [rob_pkg::xlen-1:0]        alu_operand_a,
    input  logic [rob_pkg::xlen-1:0]        alu_operand_b,
    output logic                            alu_ready,
    // AGU issue
    input  logic                            agu_issue_valid,
    input  logic [rob_pkg::rob_tag_len-1:0] agu_issue_tag,
    input  logic [rob_pkg::xlen-1:0]        agu_base,
    input  logic [rob_pkg::xlen-1:0]        agu_offset,
    output logic                            agu_ready,
    input  logic [rob_pkg::rob_tag_len-1:0] read_tag,
    output logic [rob_pkg::xlen-1:0]        read_value,
    input  logic [rob_pkg::rob_tag_len-1:0] load_tag,
    input  logic [rob_pkg::xlen-1:0]        load_address,
    output logic                            pending_stores,
    // commit, taken from the head entry
    output logic                            commit_valid,
    output logic                            commit_is_store,
    output logic [4:0]                      commit_dest_reg,
    output logic [rob_pkg::xlen-1:0]        commit_value,
    output logic [rob_pkg::xlen-1:0]        commit_address
);
    import rob_pkg::*;

    cdb_data_t  cdb;
    rob_entry_t head_entry;

    fu_result_if alu_result_bus ();
    fu_result_if agu_result_bus ();

    alu_unit i_alu_unit (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (alu_issue_valid),
        .issue_tag   (alu_issue_tag),
        .issue_op    (alu_issue_op),
        .operand_a   (alu_operand_a),
        .operand_b   (alu_operand_b),
        .issue_ready (alu_ready),
        .result      (alu_result_bus.producer)
    );

    agu_unit i_agu_unit (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (agu_issue_valid),
        .issue_tag   (agu_issue_tag),
        .base        (agu_base),
        .offset      (agu_offset),
        .issue_ready (agu_ready),
        .result      (agu_result_bus.producer)
    );

    cdb_arbiter i_cdb_arbiter (
        .clock      (clock),
        .reset      (reset),
        .alu_result (alu_result_bus.consumer),
        .agu_result (agu_result_bus.consumer),
        .cdb        (cdb)
    );

    rob i_rob (
        .clock                (clock),
        .reset                (reset),
        .alloc_enable         (alloc_enable),
        .alloc_wr_mem         (alloc_is_store),
        .alloc_value_in       (alloc_store_value),
        .alloc_value_in_valid (alloc_store_value_valid),
        .alloc_store_dep      (alloc_store_dep),
        .dest_reg             (alloc_dest_reg),
        .cdb                  (cdb),
        .read_rob_tag         (read_tag),
        .load_address         (load_address),
        .load_rob_tag         (load_tag),
        .full                 (full),
        .alloc_slot           (alloc_tag),
        .read_value           (read_value),
        .pending_stores       (pending_stores),
        .head_entry           (head_entry),
        .head_ready           (commit_valid)
    );

    assign commit_is_store = head_entry.wr_mem;
    assign commit_dest_reg = head_entry.dest_reg;
    assign commit_value    = head_entry.value;
    assign commit_address  = head_entry.dest_addr;

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        repeat (8) @(posedge clock);
        reset <= 1'b0; // released on a rising edge
    end

    always #4 clock = ~clock; // 8 ns period

endmodule

`default_nettype wire

// ==== sim/rob_core_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module rob_core_asserts (
    input logic                            clock,
    input logic                            reset,
    input logic                            alloc_enable,
    input logic                            full,
    input logic [rob_pkg::rob_tag_len-1:0] alloc_tag,
    input rob_pkg::cdb_data_t              cdb,
    input logic                            commit_valid,
    input logic                            agu_valid,
    input logic                            agu_taken,
    input logic [rob_pkg::rob_tag_len-1:0] agu_tag,
    input logic [rob_pkg::xlen-1:0]        agu_value
);

    int failures = 0;

    // a refused allocation leaves the tail where it was
    no_alloc_when_full: assert property (@(posedge clock) disable iff (reset)
        full && alloc_enable |=> alloc_tag == $past(alloc_tag))
    else begin
        $error("allocation was accepted while the ROB was full");
        failures++;
    end

    cdb_idle_after_reset: assert property (@(posedge clock) reset |=> !cdb.valid)
    else begin
        $error("CDB valid was high right after reset");
        failures++;
    end

    // only the AGU can lose at the arbiter
    agu_result_held: assert property (@(posedge clock) disable iff (reset)
        agu_valid && !agu_taken |=> agu_valid && $stable(agu_tag) && $stable(agu_value))
    else begin
        $error("stalled AGU result changed before the arbiter took it");
        failures++;
    end

    commit_known: assert property (@(posedge clock) disable iff (reset)
        !$isunknown(commit_valid))
    else begin
        $error("commit_valid is unknown");
        failures++;
    end

endmodule

`default_nettype wire

// ==== sim/rob_core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rob_core_tb;
    import rob_pkg::*;

    typedef struct packed {
        logic            store;
        logic [4:0]      dest;
        logic [xlen-1:0] value;
        logic [xlen-1:0] address; // only meaningful for stores
    } commit_t;

    localparam int clock_period    = 8;
    localparam int op_count        = 6 + rob_size + 1 + 4 + 3 + 2;
    localparam int watchdog_cycles = 8 + 30 * op_count;

    logic                   clock;
    logic                   reset;
    logic                   alloc_enable;
    logic                   alloc_is_store;
    logic [4:0]             alloc_dest_reg;
    logic [xlen-1:0]        alloc_store_value;
    logic                   alloc_store_value_valid;
    logic [rob_tag_len-1:0] alloc_store_dep;
    logic [rob_tag_len-1:0] alloc_tag;
    logic                   full;
    logic                   alu_issue_valid;
    logic [rob_tag_len-1:0] alu_issue_tag;
    alu_op_t                alu_issue_op;
    logic [xlen-1:0]        alu_operand_a;
    logic [xlen-1:0]        alu_operand_b;
    logic                   alu_ready;
    logic                   agu_issue_valid;
    logic [rob_tag_len-1:0] agu_issue_tag;
    logic [xlen-1:0]        agu_base;
    logic [xlen-1:0]        agu_offset;
    logic                   agu_ready;
    logic [rob_tag_len-1:0] read_tag;
    logic [xlen-1:0]        read_value;
    logic [rob_tag_len-1:0] load_tag;
    logic [xlen-1:0]        load_address;
    logic                   pending_stores;
    logic                   commit_valid;
    logic                   commit_is_store;
    logic [4:0]             commit_dest_reg;
    logic [xlen-1:0]        commit_value;
    logic [xlen-1:0]        commit_address;

    int                     errors = 0;
    int                     next_tag = 0;      // model of the ROB tail
    logic [rob_tag_len-1:0] last_alloc_tag = '0;
    logic [31:0]            lcg_state = 32'd97;
    commit_t                exp_q [$];         // expected commits, oldest first
    alu_op_t                op_of [rob_size];
    logic [xlen-1:0]        a_of [rob_size];
    logic [xlen-1:0]        b_of [rob_size];
    logic [xlen-1:0]        res_of [rob_size];
    logic [xlen-1:0]        base_of [rob_size];
    logic [xlen-1:0]        off_of [rob_size];

    tb_clock_gen i_tb_clock_gen (.clock(clock), .reset(reset));

    rob_core_top i_rob_core_top (.*);

    bind rob_core_top rob_core_asserts i_rob_core_asserts (
        .clock        (clock),
        .reset        (reset),
        .alloc_enable (alloc_enable),
        .full         (full),
        .alloc_tag    (alloc_tag),
        .cdb          (cdb),
        .commit_valid (commit_valid),
        .agu_valid    (agu_result_bus.valid),
        .agu_taken    (agu_result_bus.ready),
        .agu_tag      (agu_result_bus.rob_tag),
        .agu_value    (agu_result_bus.value)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [xlen-1:0] alu_model(input alu_op_t op,
                                                  input logic [xlen-1:0] a,
                                                  input logic [xlen-1:0] b);
        case (op)
            alu_add: return a + b;
            alu_sub: return a - b;
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_xor: return a ^ b;
            alu_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [xlen-1:0] got,
                               input logic [xlen-1:0] want);
        if (got !== want) begin
            $display("FAIL %s got %h expected %h", name, got, want);
            errors++;
        end
    endtask

    // strobes last one cycle unless driven again after this
    task automatic cycle();
        @(posedge clock);
        alloc_enable    <= 1'b0;
        alu_issue_valid <= 1'b0;
        agu_issue_valid <= 1'b0;
    endtask

    task automatic alloc_entry(input logic is_store, input logic [xlen-1:0] data,
                               input logic data_ok, input int dep,
                               input logic [xlen-1:0] exp_value,
                               input logic [xlen-1:0] exp_address);
        commit_t entry;
        entry.store             = is_store;
        entry.dest              = 5'(lcg_next());
        entry.value             = exp_value;
        entry.address           = exp_address;
        alloc_enable            <= 1'b1;
        alloc_is_store          <= is_store;
        alloc_dest_reg          <= entry.dest;
        alloc_store_value       <= data;
        alloc_store_value_valid <= data_ok;
        alloc_store_dep         <= rob_tag_len'(dep);
        exp_q.push_back(entry);
        last_alloc_tag = rob_tag_len'(next_tag);
        next_tag       = (next_tag + 1) % rob_size;
    endtask

    task automatic alloc_alu(output int tag);
        logic [2:0] code;
        code        = 3'((lcg_next() >> 16) % 6);
        tag         = next_tag;
        op_of[tag]  = alu_op_t'(code);
        a_of[tag]   = lcg_next();
        b_of[tag]   = lcg_next();
        res_of[tag] = alu_model(op_of[tag], a_of[tag], b_of[tag]);
        alloc_entry(1'b0, '0, 1'b0, 0, res_of[tag], '0);
    endtask

    // store data comes with the allocation or later from producer dep
    task automatic alloc_store(input int dep, input logic data_ok, output int tag);
        logic [xlen-1:0] data;
        data         = lcg_next();
        tag          = next_tag;
        base_of[tag] = lcg_next();
        off_of[tag]  = lcg_next() & 32'h0000_0fff;
        res_of[tag]  = data_ok ? data : res_of[dep];
        alloc_entry(1'b1, data, data_ok, dep, res_of[tag], base_of[tag] + off_of[tag]);
    endtask

    // a load whose value is its address, computed by the AGU
    task automatic alloc_load(output int tag);
        tag          = next_tag;
        base_of[tag] = lcg_next();
        off_of[tag]  = lcg_next() & 32'h0000_0fff;
        res_of[tag]  = base_of[tag] + off_of[tag];
        alloc_entry(1'b0, '0, 1'b0, 0, res_of[tag], '0);
    endtask

    task automatic issue_alu(input int tag);
        alu_issue_valid <= 1'b1;
        alu_issue_tag   <= rob_tag_len'(tag);
        alu_issue_op    <= op_of[tag];
        alu_operand_a   <= a_of[tag];
        alu_operand_b   <= b_of[tag];
    endtask

    task automatic issue_agu(input int tag);
        agu_issue_valid <= 1'b1;
        agu_issue_tag   <= rob_tag_len'(tag);
        agu_base        <= base_of[tag];
        agu_offset      <= off_of[tag];
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) @(negedge clock);
    endtask

    // commits and allocation tags, sampled mid-cycle
    always @(negedge clock) begin
        commit_t head_exp;
        if (!reset && commit_valid) begin
            if (exp_q.size() == 0) begin
                $display("unexpected commit while no instruction was outstanding");
                errors++;
            end else begin
                head_exp = exp_q.pop_front();
                check_value("commit_is_store", commit_is_store, head_exp.store);
                check_value("commit_dest_reg", commit_dest_reg, head_exp.dest);
                check_value("commit_value", commit_value, head_exp.value);
                if (head_exp.store) begin
                    check_value("commit_address", commit_address, head_exp.address);
                end
            end
        end
        if (!reset && alloc_enable && !full) begin
            check_value("alloc_tag", alloc_tag, last_alloc_tag);
        end
    end

    initial begin
        #(watchdog_cycles * clock_period);
        $display("timeout after %0d cycles, the test sequence did not finish", watchdog_cycles);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        int              tags [rob_size];
        int              tag;
        int              j;
        int              swap;
        int              p1;
        int              s1;
        int              p2;
        int              s2;
        int              h;
        int              s;
        int              l;
        int              x;
        int              y;
        logic [xlen-1:0] addr;
        alloc_enable            = 1'b0;
        alloc_is_store          = 1'b0;
        alloc_dest_reg          = '0;
        alloc_store_value       = '0;
        alloc_store_value_valid = 1'b0;
        alloc_store_dep         = '0;
        alu_issue_valid         = 1'b0;
        alu_issue_tag           = '0;
        alu_issue_op            = alu_add;
        alu_operand_a           = '0;
        alu_operand_b           = '0;
        agu_issue_valid         = 1'b0;
        agu_issue_tag           = '0;
        agu_base                = '0;
        agu_offset              = '0;
        read_tag                = '0;
        load_tag                = '0;
        load_address            = '0;
        @(negedge reset);

        // random ALU ops completed out of order
        for (int i = 0; i < 6; i++) begin
            cycle();
            alloc_alu(tags[i]);
        end
        for (int i = 5; i > 0; i--) begin
            j       = int'((lcg_next() >> 8) % (i + 1));
            swap    = tags[i];
            tags[i] = tags[j];
            tags[j] = swap;
        end
        for (int i = 0; i < 6; i++) begin
            cycle();
            issue_alu(tags[i]);
        end
        wait_drained();

        // fill up, try one more, then free the head
        for (int i = 0; i < rob_size; i++) begin
            cycle();
            alloc_alu(tags[i]);
        end
        cycle();
        @(negedge clock);
        check_value("full", full, 1'b1);
        cycle();
        alloc_enable <= 1'b1; // must be refused
        cycle();
        @(negedge clock);
        check_value("full", full, 1'b1);
        check_value("alloc_tag", alloc_tag, tags[0]);
        cycle();
        issue_alu(tags[0]);
        while (exp_q.size() == rob_size) @(negedge clock);
        cycle();
        alloc_alu(tag);
        cycle();
        @(negedge clock);
        check_value("full", full, 1'b1);
        for (int i = 1; i <= rob_size; i++) begin
            cycle();
            issue_alu(i < rob_size ? tags[i] : tag);
        end
        wait_drained();

        // store data forwarded later and in the allocating cycle
        cycle();
        alloc_alu(p1);
        cycle();
        alloc_store(p1, 1'b0, s1);
        cycle();
        alloc_alu(p2);
        cycle();
        issue_agu(s1);
        cycle();
        issue_alu(p1);
        cycle();
        issue_alu(p2);
        repeat (3) cycle(); // p2 result is on the CDB now
        alloc_store(p2, 1'b0, s2);
        cycle();
        issue_agu(s2);
        wait_drained();

        // pending store query, then the read port
        cycle();
        alloc_alu(h);
        cycle();
        alloc_store(0, 1'b1, s);
        cycle();
        alloc_alu(l);
        addr = base_of[s] + off_of[s];
        cycle();
        load_tag     <= rob_tag_len'(l);
        load_address <= addr;
        @(negedge clock);
        check_value("pending_stores", pending_stores, 1'b0); // address not known yet
        cycle();
        issue_agu(s);
        repeat (3) cycle();
        @(negedge clock);
        check_value("pending_stores", pending_stores, 1'b1);
        cycle();
        load_address <= addr ^ 32'h0000_0010;
        @(negedge clock);
        check_value("pending_stores", pending_stores, 1'b0);
        cycle();
        load_tag     <= rob_tag_len'(h);
        load_address <= addr;
        @(negedge clock);
        check_value("pending_stores", pending_stores, 1'b0);
        cycle();
        issue_alu(l);
        read_tag <= rob_tag_len'(l);
        repeat (4) cycle();
        @(negedge clock);
        check_value("read_value", read_value, res_of[l]);
        cycle();
        issue_alu(h);
        wait_drained();

        // ALU and AGU results meet at the arbiter
        cycle();
        alloc_alu(x);
        cycle();
        alloc_load(y);
        cycle();
        issue_alu(x);
        cycle();
        issue_agu(y);
        cycle();
        @(negedge clock);
        check_value("agu_ready", agu_ready, 1'b0);
        check_value("alu_ready", alu_ready, 1'b1); // the ALU wins, so it keeps issuing
        wait_drained();

        repeat (4) cycle();
        $display("errors: %0d value checks, %0d assertion failures", errors,
                 i_rob_core_top.i_rob_core_asserts.failures);
        if (errors == 0 && i_rob_core_top.i_rob_core_asserts.failures == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
src/rob_pkg.sv
src/fu_result_if.sv
src/alu_unit.sv
src/agu_unit.sv
src/cdb_arbiter.sv
src/rob.sv
src/rob_core_top.sv
sim/tb_clock_gen.sv
sim/rob_core_asserts.sv
sim/rob_core_tb.sv

// ==== Makefile ====
SIM       := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := rob_core_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
RUN_ARGS  := +verilator+error+limit+1000
PASS_TEXT := Testbench passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(OBJ_DIR)
